/* design/pe_pkg.sv */
package pe_pkg;

    //////////////////////////////
    // Data words
    //////////////////////////////

    typedef logic signed [7:0]  act_t;   // Input feature value
    typedef logic signed [7:0]  wgt_t;   // Filter tap
    typedef logic signed [23:0] psum_t;  // Holds 16 full products

    //////////////////////////////
    // Job configuration
    //////////////////////////////

    typedef enum logic {
        MODE_CONV = 1'b0,
        MODE_ADD  = 1'b1
    } pe_mode_e;

    typedef struct packed {
        pe_mode_e   mode;
        logic [3:0] stride;    // 1 to 15
        logic [4:0] filt_len;
        logic [5:0] if_len;
        logic [5:0] n_psum;    // Incoming sums per accumulate job
    } pe_cfg_t;

    typedef struct packed {
        logic [5:0] idx;       // Window position
        psum_t      value;
    } psum_msg_t;

    //////////////////////////////
    // Link credits
    //////////////////////////////

    localparam int OUT_CREDITS = 4;
    localparam int IN_CREDITS  = 4;

endpackage

/* design/scratchpad.sv */
`timescale 1ns/1ps

module scratchpad #(
    parameter int  DEPTH  = 32,
    parameter type elem_t = logic [7:0]
) (
    input  logic                     clk,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  elem_t                    wr_data,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output elem_t                    rd_data
);

    elem_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];  // One cycle read
    end

endmodule

/* design/mac_unit.sv */
`timescale 1ns/1ps

module mac_unit import pe_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  tap_valid,
    input  logic  first_tap,
    input  logic  last_tap,
    input  act_t  act,
    input  wgt_t  wgt,
    output logic  mac_valid,
    output psum_t mac_sum
);

    logic signed [15:0] prod;
    psum_t              acc;

    assign prod = act * wgt;

    always_ff @(posedge clk) begin
        if (tap_valid) begin
            acc <= (first_tap ? '0 : acc) + psum_t'(prod);  // New window restarts
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mac_valid <= 1'b0;
        end else begin
            mac_valid <= tap_valid && last_tap;
        end
    end

    assign mac_sum = acc;

endmodule

/* design/window_addr_gen.sv */
`timescale 1ns/1ps

module window_addr_gen import pe_pkg::*; #(
    parameter int IF_DEPTH   = 32,
    parameter int FILT_DEPTH = 16
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          gen_start,
    input  logic                          stall,
    input  pe_cfg_t                       job_cfg,
    output logic [$clog2(IF_DEPTH)-1:0]   if_rd_addr,
    output logic [$clog2(FILT_DEPTH)-1:0] filt_rd_addr,
    output logic                          tap_valid,
    output logic                          first_tap,
    output logic                          last_tap,
    output logic                          win_done
);

    localparam int IA = $clog2(IF_DEPTH);
    localparam int FA = $clog2(FILT_DEPTH);

    logic [IA-1:0] base;
    logic [FA-1:0] tap;
    logic          active;
    logic          issue;
    logic          at_last_tap;
    logic          at_last_win;

    assign issue       = active && !stall;
    assign at_last_tap = int'(tap) == int'(job_cfg.filt_len) - 1;
    // Next window would run past the input row
    assign at_last_win = int'(base) + int'(job_cfg.stride) + int'(job_cfg.filt_len) >
                         int'(job_cfg.if_len);

    assign if_rd_addr   = base + IA'(tap);
    assign filt_rd_addr = tap;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active <= 1'b0;
            base   <= '0;
            tap    <= '0;
        end else if (gen_start) begin
            active <= 1'b1;
            base   <= '0;
            tap    <= '0;
        end else if (issue) begin
            if (at_last_tap) begin
                tap <= '0;
                if (at_last_win) begin
                    active <= 1'b0;
                end else begin
                    base <= base + IA'(job_cfg.stride);
                end
            end else begin
                tap <= tap + 1'b1;
            end
        end
    end

    // Flags trail the address by the scratchpad read latency
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tap_valid <= 1'b0;
            first_tap <= 1'b0;
            last_tap  <= 1'b0;
            win_done  <= 1'b0;
        end else begin
            tap_valid <= issue;
            first_tap <= issue && tap == '0;
            last_tap  <= issue && at_last_tap;
            win_done  <= issue && at_last_tap && at_last_win;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        issue |-> int'(if_rd_addr) < int'(job_cfg.if_len));

endmodule

/* design/psum_buffer.sv */
`timescale 1ns/1ps

module psum_buffer import pe_pkg::*; #(
    parameter int PSUM_DEPTH = 32
) (
    input  logic      clk,
    input  logic      rst,
    input  pe_cfg_t   job_cfg,
    input  logic      add_en,
    input  logic      mac_valid,
    input  psum_t     mac_sum,
    input  logic      in_valid,
    input  psum_msg_t in_msg,
    output logic      in_credit,
    output logic      out_valid,
    output psum_msg_t out_msg,
    input  logic      out_credit,
    output logic      out_room,
    output logic      add_done
);

    localparam int PA = $clog2(PSUM_DEPTH);
    localparam int QA = $clog2(IN_CREDITS);
    localparam int QW = QA + 1;
    localparam int CW = $clog2(OUT_CREDITS + 1);

    psum_t         mem  [PSUM_DEPTH];
    psum_msg_t     fifo [IN_CREDITS];
    logic [QA-1:0] fifo_wr;
    logic [QA-1:0] fifo_rd;
    logic [QW-1:0] fifo_cnt;
    logic [CW-1:0] credits;
    logic [CW-1:0] avail;
    logic [5:0]    wr_idx;
    logic [5:0]    send_idx;
    logic [5:0]    pend_cnt;
    logic [5:0]    pop_cnt;
    logic          conv_send;
    logic          pop;
    logic          pop_last;
    logic          add_vld;
    logic          add_last;
    logic          out_last;
    psum_msg_t     head;
    psum_msg_t     add_msg;
    psum_msg_t     conv_msg;
    psum_t         add_sum;

    // Window index wraps after the last window, so each job starts at zero
    function automatic logic is_last_win(logic [5:0] idx, pe_cfg_t c);
        logic [10:0] end_pos;
        end_pos = 11'(idx) * 11'(c.stride) + 11'(c.stride) + 11'(c.filt_len);
        return end_pos > 11'(c.if_len);
    endfunction

    //////////////////////////////
    // Send decision
    //////////////////////////////

    assign avail     = credits - CW'(out_valid) - CW'(add_vld);  // Unreserved credits
    assign out_room  = avail != '0 && pend_cnt == '0;
    assign conv_send = (mac_valid || pend_cnt != '0) && avail != '0 && !add_vld;
    assign conv_msg  = '{idx: send_idx,
                         value: (pend_cnt != '0) ? mem[send_idx[PA-1:0]] : mac_sum};

    assign head     = fifo[fifo_rd];
    assign pop      = add_en && fifo_cnt != '0 && avail != '0;
    assign pop_last = pop_cnt == job_cfg.n_psum - 6'd1;
    assign add_sum  = mem[head.idx[PA-1:0]] + head.value;
    assign add_done = out_valid && out_last;

    //////////////////////////////
    // Storage
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (in_valid) begin
            fifo[fifo_wr] <= in_msg;
        end
        if (pop) begin
            mem[head.idx[PA-1:0]] <= add_sum;
            add_msg               <= '{idx: head.idx, value: add_sum};
        end else if (mac_valid) begin
            mem[wr_idx[PA-1:0]] <= mac_sum;
        end
        if (add_vld) begin
            out_msg <= add_msg;
        end else if (conv_send) begin
            out_msg <= conv_msg;
        end
    end

    //////////////////////////////
    // Counters and handshakes
    //////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credits   <= CW'(OUT_CREDITS);
            out_valid <= 1'b0;
            out_last  <= 1'b0;
            add_vld   <= 1'b0;
            add_last  <= 1'b0;
            in_credit <= 1'b0;
            fifo_wr   <= '0;
            fifo_rd   <= '0;
            fifo_cnt  <= '0;
            wr_idx    <= '0;
            send_idx  <= '0;
            pend_cnt  <= '0;
            pop_cnt   <= '0;
        end else begin
            credits   <= credits - CW'(out_valid) + CW'(out_credit);
            out_valid <= add_vld || conv_send;
            out_last  <= add_vld && add_last;
            add_vld   <= pop;
            in_credit <= pop;  // Entry freed
            fifo_cnt  <= fifo_cnt + QW'(in_valid) - QW'(pop);
            pend_cnt  <= pend_cnt + 6'(mac_valid) - 6'(conv_send);
            if (in_valid) begin
                fifo_wr <= fifo_wr + 1'b1;
            end
            if (pop) begin
                fifo_rd  <= fifo_rd + 1'b1;
                add_last <= pop_last;
                pop_cnt  <= pop_last ? '0 : pop_cnt + 6'd1;
            end
            if (mac_valid) begin
                wr_idx <= is_last_win(wr_idx, job_cfg) ? '0 : wr_idx + 6'd1;
            end
            if (conv_send) begin
                send_idx <= is_last_win(send_idx, job_cfg) ? '0 : send_idx + 6'd1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) out_valid |-> credits != '0);

    // Receiver never hands back more than was sent
    assert property (@(posedge clk) disable iff (rst)
        out_credit |-> credits < CW'(OUT_CREDITS));

    assert property (@(posedge clk) disable iff (rst) in_valid |-> fifo_cnt < QW'(IN_CREDITS));

endmodule

/* design/pe_controller.sv */
`timescale 1ns/1ps

module pe_controller import pe_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    start,
    input  pe_cfg_t cfg,
    input  logic    win_done,
    input  logic    add_done,
    input  logic    out_room,
    output logic    gen_start,
    output logic    stall,
    output logic    add_en,
    output logic    busy,
    output logic    done,
    output pe_cfg_t job_cfg
);

    typedef enum logic [2:0] {
        IDLE,
        LATCH,
        CONV,
        DRAIN,
        ADD,
        FINISH
    } state_e;

    state_e     state;
    state_e     state_nxt;
    logic [1:0] drain_cnt;
    logic       accept;

    assign accept = start && !busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= IDLE;
            job_cfg   <= '0;
            drain_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (accept) begin
                job_cfg <= cfg;
            end
            drain_cnt <= (state == DRAIN && drain_cnt != 2'd2) ? drain_cnt + 2'd1 :
                         (state == DRAIN) ? drain_cnt : 2'd0;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    state_nxt = accept ? LATCH : IDLE;
            LATCH:   state_nxt = (job_cfg.mode == MODE_ADD) ? ADD : CONV;
            CONV:    state_nxt = win_done ? DRAIN : CONV;
            DRAIN:   state_nxt = (drain_cnt == 2'd2 && out_room) ? FINISH : DRAIN;  // Last sums leave
            ADD:     state_nxt = add_done ? FINISH : ADD;
            FINISH:  state_nxt = accept ? LATCH : IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    assign busy      = state inside {LATCH, CONV, DRAIN, ADD};
    assign done      = state == FINISH;
    assign gen_start = state == LATCH && job_cfg.mode == MODE_CONV;
    assign stall     = state == CONV && !out_room;  // Hold taps until a credit frees
    assign add_en    = state == ADD;

    // Address generator ends a window sweep only inside a convolve job
    assert property (@(posedge clk) disable iff (rst)
        win_done |-> state == CONV);

    // Last accumulate send only inside an accumulate job
    assert property (@(posedge clk) disable iff (rst)
        add_done |-> state == ADD);

endmodule

/* design/conv_pe_top.sv */
`timescale 1ns/1ps

module conv_pe_top import pe_pkg::*; #(
    parameter int IF_DEPTH   = 32,
    parameter int FILT_DEPTH = 16,
    parameter int PSUM_DEPTH = 32
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          if_wr_valid,
    input  logic [$clog2(IF_DEPTH)-1:0]   if_wr_addr,
    input  act_t                          if_wr_data,
    input  logic                          filt_wr_valid,
    input  logic [$clog2(FILT_DEPTH)-1:0] filt_wr_addr,
    input  wgt_t                          filt_wr_data,
    input  logic                          start,
    input  pe_cfg_t                       cfg,
    output logic                          busy,
    output logic                          done,
    output logic                          out_valid,
    output psum_msg_t                     out_msg,
    input  logic                          out_credit,
    input  logic                          in_valid,
    input  psum_msg_t                     in_msg,
    output logic                          in_credit
);

    logic                          gen_start;
    logic                          stall;
    logic                          add_en;
    logic                          win_done;
    logic                          add_done;
    logic                          out_room;
    pe_cfg_t                       job_cfg;
    logic [$clog2(IF_DEPTH)-1:0]   if_rd_addr;
    logic [$clog2(FILT_DEPTH)-1:0] filt_rd_addr;
    logic                          tap_valid;
    logic                          first_tap;
    logic                          last_tap;
    act_t                          act;
    wgt_t                          wgt;
    logic                          mac_valid;
    psum_t                         mac_sum;

    pe_controller u_pe_controller (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .cfg       (cfg),
        .win_done  (win_done),
        .add_done  (add_done),
        .out_room  (out_room),
        .gen_start (gen_start),
        .stall     (stall),
        .add_en    (add_en),
        .busy      (busy),
        .done      (done),
        .job_cfg   (job_cfg)
    );

    window_addr_gen #(
        .IF_DEPTH   (IF_DEPTH),
        .FILT_DEPTH (FILT_DEPTH)
    ) u_window_addr_gen (
        .clk          (clk),
        .rst          (rst),
        .gen_start    (gen_start),
        .stall        (stall),
        .job_cfg      (job_cfg),
        .if_rd_addr   (if_rd_addr),
        .filt_rd_addr (filt_rd_addr),
        .tap_valid    (tap_valid),
        .first_tap    (first_tap),
        .last_tap     (last_tap),
        .win_done     (win_done)
    );

    scratchpad #(.DEPTH(IF_DEPTH), .elem_t(act_t)) u_if_spad (
        .clk     (clk),
        .wr_en   (if_wr_valid),
        .wr_addr (if_wr_addr),
        .wr_data (if_wr_data),
        .rd_addr (if_rd_addr),
        .rd_data (act)
    );

    scratchpad #(.DEPTH(FILT_DEPTH), .elem_t(wgt_t)) u_filt_spad (
        .clk     (clk),
        .wr_en   (filt_wr_valid),
        .wr_addr (filt_wr_addr),
        .wr_data (filt_wr_data),
        .rd_addr (filt_rd_addr),
        .rd_data (wgt)
    );

    mac_unit u_mac_unit (
        .clk       (clk),
        .rst       (rst),
        .tap_valid (tap_valid),
        .first_tap (first_tap),
        .last_tap  (last_tap),
        .act       (act),
        .wgt       (wgt),
        .mac_valid (mac_valid),
        .mac_sum   (mac_sum)
    );

    psum_buffer #(.PSUM_DEPTH(PSUM_DEPTH)) u_psum_buffer (
        .clk        (clk),
        .rst        (rst),
        .job_cfg    (job_cfg),
        .add_en     (add_en),
        .mac_valid  (mac_valid),
        .mac_sum    (mac_sum),
        .in_valid   (in_valid),
        .in_msg     (in_msg),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_msg    (out_msg),
        .out_credit (out_credit),
        .out_room   (out_room),
        .add_done   (add_done)
    );

endmodule

/* verif/conv_pe_tb.sv */
`timescale 1ns/1ps

module conv_pe_tb import pe_pkg::*; ();

    localparam int    IF_DEPTH   = 32;
    localparam int    FILT_DEPTH = 16;
    localparam int    PSUM_DEPTH = 32;
    localparam string STIM       = "verif/conv_pe_stim.txt";

    logic                          clk;
    logic                          rst;
    logic                          if_wr_valid;
    logic [$clog2(IF_DEPTH)-1:0]   if_wr_addr;
    act_t                          if_wr_data;
    logic                          filt_wr_valid;
    logic [$clog2(FILT_DEPTH)-1:0] filt_wr_addr;
    wgt_t                          filt_wr_data;
    logic                          start;
    pe_cfg_t                       cfg;
    logic                          busy;
    logic                          done;
    logic                          out_valid;
    psum_msg_t                     out_msg;
    logic                          out_credit;
    logic                          in_valid;
    psum_msg_t                     in_msg;
    logic                          in_credit;

    int        errors;
    int        cycle;
    int        limit;
    int        msg_cnt;
    int        done_cnt;
    int        job_no;
    int        outstanding;  // Messages not yet credited back
    int        in_cred;      // Sender credits on the input link
    bit        bp_mode;
    psum_msg_t exp_q[$];
    psum_msg_t exp_next[$];
    psum_msg_t send_q[$];
    int        due_q[$];     // Cycles at which credits go back

    conv_pe_top #(
        .IF_DEPTH   (IF_DEPTH),
        .FILT_DEPTH (FILT_DEPTH),
        .PSUM_DEPTH (PSUM_DEPTH)
    ) u_conv_pe_top (.*);

    //////////////////////////////
    // Clock, receiver, monitor
    //////////////////////////////

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    initial begin
        out_credit = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (due_q.size() != 0 && due_q[0] <= cycle) begin
                out_credit = 1'b1;  // One message consumed
                due_q.delete(0);
            end else begin
                out_credit = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            if (out_valid) begin
                msg_cnt++;
                outstanding++;
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("message for idx %0d arrived while none was expected", out_msg.idx);
                end else begin
                    check_msg(out_msg, exp_q.pop_front());
                end
                due_q.push_back(cycle + (bp_mode ? int'($urandom_range(3, 0)) : 0));
            end
            if (out_credit) begin
                outstanding--;
            end
            if (outstanding > OUT_CREDITS) begin
                errors++;
                $display("%0d messages outstanding with only %0d credits", outstanding,
                         OUT_CREDITS);
            end
            if (in_credit) begin
                in_cred++;
            end
            if (done) begin
                done_cnt++;
                check_flag("busy", busy, 1'b0);  // Falls together with done
            end
        end
    end

    initial begin
        wait (limit > 0);
        wait (cycle >= limit);
        errors++;
        $display("timeout, the run did not end within %0d cycles", limit);
        finish_run();
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic check_msg(input psum_msg_t got, input psum_msg_t exp);
        if (got !== exp) begin
            errors++;
            $display("error out_msg got idx %h value %h, expected idx %h value %h",
                     got.idx, got.value, exp.idx, exp.value);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("error %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("errors %0d, messages %0d, jobs %0d", errors, msg_cnt, job_no);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    //////////////////////////////
    // Stim file
    //////////////////////////////

    task automatic load_row(input int fd, input bit is_filt);
        int n;
        int k;
        int val;
        check_flag("busy", busy, 1'b0);
        void'($fscanf(fd, "%h", n));
        for (k = 0; k < n; k++) begin
            void'($fscanf(fd, "%h", val));
            filt_wr_valid = is_filt;
            filt_wr_addr  = k[3:0];
            filt_wr_data  = val[7:0];
            if_wr_valid   = !is_filt;
            if_wr_addr    = k[4:0];
            if_wr_data    = val[7:0];
            @(posedge clk);
            #1;
        end
        filt_wr_valid = 1'b0;
        if_wr_valid   = 1'b0;
    endtask

    task automatic read_pairs(input int fd, input bit expected);
        int        n;
        int        k;
        int        idx;
        int        val;
        psum_msg_t m;
        void'($fscanf(fd, "%h", n));
        for (k = 0; k < n; k++) begin
            void'($fscanf(fd, "%h %h", idx, val));
            m.idx   = idx[5:0];
            m.value = val[23:0];
            if (expected) begin
                exp_next.push_back(m);
            end else begin
                send_q.push_back(m);
            end
        end
    endtask

    task automatic run_job(input int fd);
        int      f [7];
        int      k;
        int      n_exp;
        int      msgs_before;
        int      done_before;
        pe_cfg_t job;
        for (k = 0; k < 7; k++) begin
            void'($fscanf(fd, "%h", f[k]));
        end
        job.mode     = pe_mode_e'(f[0][0]);
        job.stride   = f[1][3:0];
        job.filt_len = f[2][4:0];
        job.if_len   = f[3][5:0];
        job.n_psum   = f[4][5:0];
        job_no++;
        bp_mode     = f[5] != 0;
        exp_q       = exp_next;
        exp_next.delete();
        n_exp       = exp_q.size();
        msgs_before = msg_cnt;
        done_before = done_cnt;
        check_flag("busy", busy, 1'b0);
        start = 1'b1;
        cfg   = job;
        @(posedge clk);
        #1;
        start = 1'b0;
        cfg   = '0;
        check_flag("busy", busy, 1'b1);
        if (f[6] != 0) begin
            repeat (4) @(posedge clk);
            #1;
            check_flag("busy", busy, 1'b1);
            start = 1'b1;  // Must be ignored mid-job
            cfg   = '{mode: MODE_ADD, stride: 4'd1, filt_len: 5'd2, if_len: 6'd4, n_psum: 6'd1};
            @(posedge clk);
            #1;
            start = 1'b0;
            cfg   = '0;
        end
        while (send_q.size() != 0) begin
            if (in_cred > 0) begin
                in_valid = 1'b1;
                in_msg   = send_q.pop_front();
                in_cred--;
            end else begin
                in_valid = 1'b0;
            end
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
        while (done_cnt == done_before) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        #1;
        if (done_cnt - done_before != 1) begin
            errors++;
            $display("job %0d raised done %0d times", job_no, done_cnt - done_before);
        end
        if (msg_cnt - msgs_before != n_exp) begin
            errors++;
            $display("job %0d sent %0d messages where %0d were expected", job_no,
                     msg_cnt - msgs_before, n_exp);
        end
        check_flag("busy", busy, 1'b0);
        check_flag("out_valid", out_valid, 1'b0);
    endtask

    task automatic run_file(input int fd);
        string tag;
        string rest;
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "#") begin
                void'($fgets(rest, fd));
            end else if (tag == "F" || tag == "I") begin
                load_row(fd, tag == "F");
            end else if (tag == "P" || tag == "E") begin
                read_pairs(fd, tag == "E");
            end else if (tag == "C") begin
                run_job(fd);
            end else begin
                errors++;
                $display("unknown tag %s in the stim file", tag);
            end
        end
    endtask

    initial begin
        int    fd;
        int    n_lines;
        string line;
        void'($urandom(26));
        rst           = 1'b1;
        if_wr_valid   = 1'b0;
        if_wr_addr    = '0;
        if_wr_data    = '0;
        filt_wr_valid = 1'b0;
        filt_wr_addr  = '0;
        filt_wr_data  = '0;
        start         = 1'b0;
        cfg           = '0;
        in_valid      = 1'b0;
        in_msg        = '0;
        in_cred       = IN_CREDITS;
        n_lines       = 0;
        fd = $fopen(STIM, "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open the stim file %s", STIM);
        end else begin
            while ($fgets(line, fd) != 0) begin
                n_lines++;
            end
            $fclose(fd);
            limit = 200 * n_lines;
            repeat (16) @(posedge clk);
            #1;
            rst = 1'b0;
            check_flag("busy", busy, 1'b0);
            check_flag("done", done, 1'b0);
            check_flag("out_valid", out_valid, 1'b0);
            check_flag("in_credit", in_credit, 1'b0);
            fd = $fopen(STIM, "r");
            run_file(fd);
            $fclose(fd);
        end
        finish_run();
    end

endmodule

/* verif/conv_pe_stim.txt */
# F filter row, I input row: hex count then hex words from address 0
# P incoming, E expected: hex count then idx value pairs; C mode stride filt_len if_len n_psum bp busy_start
F 3 02 FD 01
I A 05 FE 07 00 FC 03 09 F8 01 06
E 4 00 000017 01 FFFFE7 02 00000A 03 00000F
E 4 04 FFFFF8 05 FFFFE3 06 00002B 07 FFFFF3
C 0 1 3 A 0 0 0
P 4 00 000064 01 FFFFCE 02 000007 03 FFFFF1
P 4 04 0003E8 05 FFFFFF 06 FFFFD5 07 000014
E 4 00 00007B 01 FFFFB5 02 000011 03 000000
E 4 04 0003E0 05 FFFFE2 06 000000 07 000007
C 1 1 3 A 8 0 0
P 4 01 00004B 03 FFFFFB 05 000014 07 00000A
E 4 01 000000 03 FFFFFB 05 FFFFF6 07 000011
C 1 1 3 A 4 0 0
F 4 03 FF FE 04
I D 01 02 FD 04 05 FA 07 08 F7 0A 0B F4 0D
E 5 00 000017 01 FFFFD1 02 000027 03 000047 04 FFFF95
C 0 2 4 D 0 0 0
E 5 00 000017 01 FFFFD1 02 000027 03 000047 04 FFFF95
C 0 2 4 D 0 1 1

/* verilog.f */
design/pe_pkg.sv
design/scratchpad.sv
design/mac_unit.sv
design/window_addr_gen.sv
design/psum_buffer.sv
design/pe_controller.sv
design/conv_pe_top.sv
verif/conv_pe_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module conv_pe_tb -o conv_pe_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/conv_pe_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" sim.log; then
    exit 1
fi
exit 0
